// ==== design/bank_recorder_top.sv ====
// no register readback and no a/d control; the sample source must supply its own strobe.
`timescale 1ns/1ps

module bank_recorder_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  recorder_pkg::sample_t    adc_sample,
    input  logic                     sample_strobe,
    input  logic                     cfg_we,
    input  routing_pkg::cfg_addr_t   cfg_addr,
    input  routing_pkg::cfg_data_t   cfg_data,
    output recorder_pkg::sample_t    chan_1,
    output recorder_pkg::sample_t    chan_2,
    output recorder_pkg::sample_t    chan_3,
    output recorder_pkg::sample_t    chan_4,
    output recorder_pkg::sample_t    chan_5,
    output recorder_pkg::sample_t    chan_6,
    output recorder_pkg::sample_t    chan_7,
    output recorder_pkg::sample_t    chan_8,
    output recorder_pkg::sample_t    chan_9,
    output recorder_pkg::sample_t    chan_10
);

    routing_pkg::route_word_t    route;
    recorder_pkg::record_mask_t  record_mask;

    recorder_pkg::sample_t play_1;
    recorder_pkg::sample_t play_2;
    recorder_pkg::sample_t play_3;
    recorder_pkg::sample_t play_4;

    route_regs route_regs_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .route       (route),
        .record_mask (record_mask)
    );

    // bank n records when mask bit n-1 is set.
    sample_bank bank_1_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe),
        .sample_in     (adc_sample),
        .record        (record_mask[0]),
        .play_out      (play_1)
    );

    sample_bank bank_2_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe),
        .sample_in     (adc_sample),
        .record        (record_mask[1]),
        .play_out      (play_2)
    );

    sample_bank bank_3_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe),
        .sample_in     (adc_sample),
        .record        (record_mask[2]),
        .play_out      (play_3)
    );

    sample_bank bank_4_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_strobe (sample_strobe),
        .sample_in     (adc_sample),
        .record        (record_mask[3]),
        .play_out      (play_4)
    );

    mem_bank_mux mem_bank_mux_inst (
        .ctrl           (route),
        .ad_passthrough (adc_sample),
        .buf_1          (play_1),
        .buf_2          (play_2),
        .buf_3          (play_3),
        .buf_4          (play_4),
        .chan_1         (chan_1),
        .chan_2         (chan_2),
        .chan_3         (chan_3),
        .chan_4         (chan_4),
        .chan_5         (chan_5),
        .chan_6         (chan_6),
        .chan_7         (chan_7),
        .chan_8         (chan_8),
        .chan_9         (chan_9),
        .chan_10        (chan_10)
    );

endmodule

// ==== design/mem_bank_mux.sv ====
// purely combinational; channels follow the select word and the live sample in the same cycle.
`timescale 1ns/1ps

module mem_bank_mux (
    input  routing_pkg::route_word_t  ctrl,
    input  recorder_pkg::sample_t     ad_passthrough,
    input  recorder_pkg::sample_t     buf_1,
    input  recorder_pkg::sample_t     buf_2,
    input  recorder_pkg::sample_t     buf_3,
    input  recorder_pkg::sample_t     buf_4,
    output recorder_pkg::sample_t     chan_1,
    output recorder_pkg::sample_t     chan_2,
    output recorder_pkg::sample_t     chan_3,
    output recorder_pkg::sample_t     chan_4,
    output recorder_pkg::sample_t     chan_5,
    output recorder_pkg::sample_t     chan_6,
    output recorder_pkg::sample_t     chan_7,
    output recorder_pkg::sample_t     chan_8,
    output recorder_pkg::sample_t     chan_9,
    output recorder_pkg::sample_t     chan_10
);

    localparam int w = routing_pkg::sel_width;

    // one source for one select code, top bit set means passthrough.
    function automatic recorder_pkg::sample_t pick_source(
        input routing_pkg::chan_sel_t sel,
        input recorder_pkg::sample_t  pass,
        input recorder_pkg::sample_t  b1,
        input recorder_pkg::sample_t  b2,
        input recorder_pkg::sample_t  b3,
        input recorder_pkg::sample_t  b4
    );
        recorder_pkg::sample_t src;
        case (sel)
            routing_pkg::sel_bank_1: src = b1;
            routing_pkg::sel_bank_2: src = b2;
            routing_pkg::sel_bank_3: src = b3;
            routing_pkg::sel_bank_4: src = b4;
            default:                 src = pass;
        endcase
        return src;
    endfunction

    always_comb
    begin
        chan_1  = pick_source(ctrl[0*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_2  = pick_source(ctrl[1*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_3  = pick_source(ctrl[2*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_4  = pick_source(ctrl[3*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_5  = pick_source(ctrl[4*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_6  = pick_source(ctrl[5*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_7  = pick_source(ctrl[6*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_8  = pick_source(ctrl[7*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_9  = pick_source(ctrl[8*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
        chan_10 = pick_source(ctrl[9*w +: w], ad_passthrough, buf_1, buf_2, buf_3, buf_4);
    end

endmodule

// ==== design/recorder_pkg.sv ====
// samples are 3 bits wide; bank depth must stay a power of two for the pointer to cover it.
package recorder_pkg;

    // width of one a/d sample.
    localparam int sample_width = 3;

    // number of recording banks.
    localparam int num_banks = 4;

    // samples held per bank before the pointer wraps.
    localparam int bank_depth = 16;

    localparam int bank_ptr_width = $clog2(bank_depth);

    // one a/d sample.
    typedef logic [sample_width-1:0] sample_t;

    // write and replay pointer of a bank.
    typedef logic [bank_ptr_width-1:0] bank_ptr_t;

    // bit n-1 sets bank n to record.
    typedef logic [num_banks-1:0] record_mask_t;

endpackage

// ==== design/route_regs.sv ====
// write-only config registers; writes to addresses 11 to 15 are dropped without any response.
`timescale 1ns/1ps

module route_regs (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cfg_we,
    input  routing_pkg::cfg_addr_t      cfg_addr,
    input  routing_pkg::cfg_data_t      cfg_data,
    output routing_pkg::route_word_t    route,
    output recorder_pkg::record_mask_t  record_mask
);

    // one select per channel, index 0 is channel 1.
    routing_pkg::chan_sel_t sel [routing_pkg::num_channels];

    logic sel_hit;
    logic mask_hit;

    // address decode.
    always_comb
    begin
        mask_hit = cfg_we && (cfg_addr == routing_pkg::addr_record_mask);
        sel_hit  = cfg_we && (cfg_addr < routing_pkg::addr_record_mask);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < routing_pkg::num_channels; i++)
            begin
                sel[i] <= routing_pkg::sel_passthrough;
            end
        end
        else if (sel_hit)
        begin
            // only the low bits of the data carry a select.
            sel[cfg_addr] <= cfg_data[routing_pkg::sel_width-1:0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            record_mask <= '0;
        end
        else if (mask_hit)
        begin
            record_mask <= recorder_pkg::record_mask_t'(cfg_data);
        end
    end

    // pack the selects, channel 1 lowest.
    always_comb
    begin
        for (int i = 0; i < routing_pkg::num_channels; i++)
        begin
            route[i*routing_pkg::sel_width +: routing_pkg::sel_width] = sel[i];
        end
    end

endmodule

// ==== design/routing_pkg.sv ====
// ten channels with 3-bit selects; any select with the top bit set means live a/d passthrough.
package routing_pkg;

    localparam int num_channels = 10;

    // bits of one channel select.
    localparam int sel_width = 3;

    localparam int route_width = num_channels * sel_width;

    localparam int cfg_addr_width = 4;
    localparam int cfg_data_width = 4;

    typedef logic [sel_width-1:0] chan_sel_t;

    // all selects packed, channel 1 in the lowest field.
    typedef logic [route_width-1:0] route_word_t;

    typedef logic [cfg_addr_width-1:0] cfg_addr_t;
    typedef logic [cfg_data_width-1:0] cfg_data_t;

    // select codes for the four banks.
    localparam chan_sel_t sel_bank_1 = 3'b000;
    localparam chan_sel_t sel_bank_2 = 3'b001;
    localparam chan_sel_t sel_bank_3 = 3'b010;
    localparam chan_sel_t sel_bank_4 = 3'b011;

    // reset value, routes the live sample.
    localparam chan_sel_t sel_passthrough = 3'b100;

    // addresses 0 to 9 hold channel 1 to 10 selects, 11 to 15 are unused.
    localparam cfg_addr_t addr_record_mask = 4'd10;

endpackage

// ==== design/sample_bank.sv ====
// one bank; steps only on sample_strobe and replays zeros until something has been recorded.
`timescale 1ns/1ps

module sample_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample_strobe,
    input  recorder_pkg::sample_t  sample_in,
    input  logic                   record,
    output recorder_pkg::sample_t  play_out
);

    // sample loop storage.
    recorder_pkg::sample_t mem [recorder_pkg::bank_depth];

    recorder_pkg::bank_ptr_t ptr;
    recorder_pkg::bank_ptr_t ptr_next;

    // last slot wraps back to the start of the loop.
    always_comb
    begin
        if (ptr == recorder_pkg::bank_ptr_t'(recorder_pkg::bank_depth - 1))
            ptr_next = '0;
        else
            ptr_next = ptr + 1'b1;
    end

    // pointer advances on every strobe, recording or not.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ptr <= '0;
        end
        else if (sample_strobe)
        begin
            ptr <= ptr_next;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < recorder_pkg::bank_depth; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (sample_strobe && record)
        begin
            mem[ptr] <= sample_in;
        end
    end

    // recording shows the new sample at once, replay shows the stored word.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            play_out <= '0;
        end
        else if (sample_strobe)
        begin
            if (record)
            begin
                play_out <= sample_in;
            end
            else
            begin
                play_out <= mem[ptr];
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal \
    -f sim.f \
    --top-module tb_bank_recorder \
    --Mdir "$build_dir" \
    -o sim_bin

"./$build_dir/sim_bin" | tee "$log_file"

if grep -qx "sim passed" "$log_file"; then
    echo "result: PASS"
    exit 0
else
    echo "result: FAIL"
    exit 1
fi

// ==== sim.f ====
design/recorder_pkg.sv
design/routing_pkg.sv
design/sample_bank.sv
design/route_regs.sv
design/mem_bank_mux.sv
design/bank_recorder_top.sv
verification/recorder_checker.sv
verification/tb_bank_recorder.sv

// ==== verification/recorder_checker.sv ====
// model updates on rising edges and channels are compared on falling edges, once reset has been seen.
`timescale 1ns/1ps

module recorder_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  recorder_pkg::sample_t    adc_sample,
    input  logic                     sample_strobe,
    input  logic                     cfg_we,
    input  routing_pkg::cfg_addr_t   cfg_addr,
    input  routing_pkg::cfg_data_t   cfg_data,
    input  recorder_pkg::sample_t    chan_1,
    input  recorder_pkg::sample_t    chan_2,
    input  recorder_pkg::sample_t    chan_3,
    input  recorder_pkg::sample_t    chan_4,
    input  recorder_pkg::sample_t    chan_5,
    input  recorder_pkg::sample_t    chan_6,
    input  recorder_pkg::sample_t    chan_7,
    input  recorder_pkg::sample_t    chan_8,
    input  recorder_pkg::sample_t    chan_9,
    input  recorder_pkg::sample_t    chan_10,
    output int                       error_count,
    output int                       check_count
);

    routing_pkg::chan_sel_t      sel_model [routing_pkg::num_channels];
    recorder_pkg::record_mask_t  mask_model;
    recorder_pkg::sample_t       mem_model [recorder_pkg::num_banks][recorder_pkg::bank_depth];
    recorder_pkg::bank_ptr_t     ptr_model [recorder_pkg::num_banks];
    recorder_pkg::sample_t       play_model [recorder_pkg::num_banks];

    logic model_valid = 1'b0;
    int   errors = 0;
    int   checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // top bit of the select means live sample, otherwise the low bits name the bank.
    function automatic recorder_pkg::sample_t expected_chan(
        input routing_pkg::chan_sel_t sel,
        input recorder_pkg::sample_t  live
    );
        recorder_pkg::sample_t value;
        if (sel[routing_pkg::sel_width-1])
            value = live;
        else
            value = play_model[sel[1:0]];
        return value;
    endfunction

    always @(posedge clk)
    begin : update_model
        if (!rst_n)
        begin
            for (int c = 0; c < routing_pkg::num_channels; c++)
                sel_model[c] = routing_pkg::sel_passthrough;
            mask_model = '0;
            for (int b = 0; b < recorder_pkg::num_banks; b++)
            begin
                ptr_model[b] = '0;
                play_model[b] = '0;
                for (int i = 0; i < recorder_pkg::bank_depth; i++)
                    mem_model[b][i] = '0;
            end
            model_valid = 1'b1;
        end
        else
        begin
            // banks use the mask as it stood before this edge's write.
            if (sample_strobe)
            begin
                for (int b = 0; b < recorder_pkg::num_banks; b++)
                begin
                    if (mask_model[b])
                    begin
                        mem_model[b][ptr_model[b]] = adc_sample;
                        play_model[b] = adc_sample;
                    end
                    else
                    begin
                        play_model[b] = mem_model[b][ptr_model[b]];
                    end
                    ptr_model[b] = recorder_pkg::bank_ptr_t'(
                        (int'(ptr_model[b]) + 1) % recorder_pkg::bank_depth);
                end
            end
            if (cfg_we)
            begin
                if (int'(cfg_addr) < routing_pkg::num_channels)
                    sel_model[cfg_addr] = cfg_data[routing_pkg::sel_width-1:0];
                else if (cfg_addr == routing_pkg::addr_record_mask)
                    mask_model = cfg_data;
            end
        end
    end

    always @(negedge clk)
    begin : compare_channels
        recorder_pkg::sample_t actual [routing_pkg::num_channels];
        recorder_pkg::sample_t expected;
        if (model_valid)
        begin
            actual[0] = chan_1;
            actual[1] = chan_2;
            actual[2] = chan_3;
            actual[3] = chan_4;
            actual[4] = chan_5;
            actual[5] = chan_6;
            actual[6] = chan_7;
            actual[7] = chan_8;
            actual[8] = chan_9;
            actual[9] = chan_10;
            for (int c = 0; c < routing_pkg::num_channels; c++)
            begin
                expected = expected_chan(sel_model[c], adc_sample);
                checks++;
                if (actual[c] !== expected)
                begin
                    errors++;
                    $display("CHECK FAILED chan_%0d expected 0x%0h actual 0x%0h at %0t",
                             c + 1, expected, actual[c], $time);
                end
            end
        end
    end

endmodule

// ==== verification/tb_bank_recorder.sv ====
// inputs change 2 ns after each rising edge; bank contents are tracked only by the checker model.
`timescale 1ns/1ps

module tb_bank_recorder;

    localparam int clk_period_ns  = 20;
    localparam int drive_delay_ns = 2;
    localparam int reset_cycles   = 5;
    localparam int seed           = 71899;

    // cycle budget per sequence with random gaps counted at their longest.
    localparam int passthrough_cycles = 12 + 4 + 8 + routing_pkg::num_channels;
    localparam int sweep_cycles       = 3 * (1 + 16) + 2
                                        + routing_pkg::num_channels * 8 * 3
                                        + routing_pkg::num_channels;
    localparam int replay_cycles      = 2 + 16 * 4 + 1 + 32 * 3 + 1;
    localparam int mixed_cycles       = 1 + 4 + 24 * 4;
    localparam int unused_cycles      = 5 * 3;
    localparam int midrun_cycles      = 1 + 6 + 4 + reset_cycles + 4 + 4 + 6 * 2;
    localparam int margin_cycles      = 40;
    localparam int total_cycles       = reset_cycles + passthrough_cycles + sweep_cycles
                                        + replay_cycles + mixed_cycles + unused_cycles
                                        + midrun_cycles;
    localparam int timeout_ns         = (total_cycles + margin_cycles) * clk_period_ns;

    logic                    clk;
    logic                    rst_n;
    recorder_pkg::sample_t   adc_sample;
    logic                    sample_strobe;
    logic                    cfg_we;
    routing_pkg::cfg_addr_t  cfg_addr;
    routing_pkg::cfg_data_t  cfg_data;
    recorder_pkg::sample_t   chan_1;
    recorder_pkg::sample_t   chan_2;
    recorder_pkg::sample_t   chan_3;
    recorder_pkg::sample_t   chan_4;
    recorder_pkg::sample_t   chan_5;
    recorder_pkg::sample_t   chan_6;
    recorder_pkg::sample_t   chan_7;
    recorder_pkg::sample_t   chan_8;
    recorder_pkg::sample_t   chan_9;
    recorder_pkg::sample_t   chan_10;
    int                      error_count;
    int                      check_count;

    initial
    begin
        clk = 1'b0;
        forever #(clk_period_ns / 2) clk = ~clk;
    end

    bank_recorder_top bank_recorder_top_inst (
        .clk (clk), .rst_n (rst_n), .adc_sample (adc_sample), .sample_strobe (sample_strobe),
        .cfg_we (cfg_we), .cfg_addr (cfg_addr), .cfg_data (cfg_data),
        .chan_1 (chan_1), .chan_2 (chan_2), .chan_3 (chan_3), .chan_4 (chan_4),
        .chan_5 (chan_5), .chan_6 (chan_6), .chan_7 (chan_7), .chan_8 (chan_8),
        .chan_9 (chan_9), .chan_10 (chan_10)
    );

    recorder_checker recorder_checker_inst (
        .clk (clk), .rst_n (rst_n), .adc_sample (adc_sample), .sample_strobe (sample_strobe),
        .cfg_we (cfg_we), .cfg_addr (cfg_addr), .cfg_data (cfg_data),
        .chan_1 (chan_1), .chan_2 (chan_2), .chan_3 (chan_3), .chan_4 (chan_4),
        .chan_5 (chan_5), .chan_6 (chan_6), .chan_7 (chan_7), .chan_8 (chan_8),
        .chan_9 (chan_9), .chan_10 (chan_10),
        .error_count (error_count), .check_count (check_count)
    );

    initial
    begin
        #(timeout_ns);
        $display("timeout: the run did not finish within %0d ns", timeout_ns);
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("sim failed");
        $finish;
    end

    // one clock cycle; the live sample changes every cycle and strobes last one cycle.
    task automatic step();
        @(posedge clk);
        #(drive_delay_ns);
        adc_sample = recorder_pkg::sample_t'($urandom);
        sample_strobe = 1'b0;
        cfg_we = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic strobe_sample();
        step();
        sample_strobe = 1'b1;
    endtask

    task automatic write_cfg(
        input routing_pkg::cfg_addr_t addr,
        input routing_pkg::cfg_data_t data
    );
        step();
        cfg_we = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
    endtask

    task automatic set_select(input int chan, input routing_pkg::chan_sel_t code);
        write_cfg(routing_pkg::cfg_addr_t'(chan - 1), routing_pkg::cfg_data_t'(code));
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        idle(reset_cycles);
        rst_n = 1'b1;
    endtask

    // channels 1 to 4 show banks 1 to 4.
    task automatic route_banks_to_first_channels();
        for (int b = 1; b <= recorder_pkg::num_banks; b++)
            set_select(b, routing_pkg::chan_sel_t'(b - 1));
    endtask

    task automatic route_all_passthrough();
        for (int c = 1; c <= routing_pkg::num_channels; c++)
            set_select(c, routing_pkg::sel_passthrough);
    endtask

    task automatic check_passthrough_after_reset();
        for (int i = 0; i < 12; i++)
        begin
            if (i % 3 == 0)
                strobe_sample();
            else
                step();
        end
        route_banks_to_first_channels();
        for (int i = 0; i < 4; i++)
        begin
            strobe_sample();
            step();
        end
        route_all_passthrough();
    endtask

    task automatic sweep_select_codes();
        // bank n is filled with the value n-1 so one replay strobe shows four distinct outputs.
        for (int b = 1; b < recorder_pkg::num_banks; b++)
        begin
            write_cfg(routing_pkg::addr_record_mask, routing_pkg::cfg_data_t'(4'hf << b));
            for (int i = 0; i < recorder_pkg::bank_depth; i++)
            begin
                strobe_sample();
                adc_sample = recorder_pkg::sample_t'(b);
            end
        end
        write_cfg(routing_pkg::addr_record_mask, '0);
        strobe_sample();
        for (int c = 1; c <= routing_pkg::num_channels; c++)
        begin
            for (int code = 0; code < 8; code++)
            begin
                set_select(c, routing_pkg::chan_sel_t'(code));
                idle(2);
            end
        end
        route_all_passthrough();
    endtask

    task automatic record_and_replay();
        write_cfg(routing_pkg::addr_record_mask, 4'b0001);
        set_select(1, routing_pkg::sel_bank_1);
        for (int i = 0; i < recorder_pkg::bank_depth; i++)
        begin
            strobe_sample();
            idle(1 + $urandom_range(2));
        end
        write_cfg(routing_pkg::addr_record_mask, '0);
        // two loops cross the pointer wrap twice.
        for (int i = 0; i < 2 * recorder_pkg::bank_depth; i++)
        begin
            strobe_sample();
            idle($urandom_range(2));
        end
        set_select(1, routing_pkg::sel_passthrough);
    endtask

    task automatic mixed_record_replay();
        write_cfg(routing_pkg::addr_record_mask, 4'b0110);
        route_banks_to_first_channels();
        for (int i = 0; i < 24; i++)
        begin
            strobe_sample();
            step();
            set_select(1 + $urandom_range(routing_pkg::num_channels - 1),
                       routing_pkg::chan_sel_t'($urandom));
            step();
        end
    endtask

    task automatic write_unused_addresses();
        for (int a = 11; a <= 15; a++)
        begin
            write_cfg(routing_pkg::cfg_addr_t'(a), routing_pkg::cfg_data_t'($urandom));
            idle(2);
        end
    endtask

    task automatic reset_mid_run();
        write_cfg(routing_pkg::addr_record_mask, 4'b1111);
        for (int i = 0; i < 6; i++)
            strobe_sample();
        route_banks_to_first_channels();
        apply_reset();
        idle(4);
        route_banks_to_first_channels();
        for (int i = 0; i < 6; i++)
        begin
            strobe_sample();
            step();
        end
    endtask

    initial
    begin
        void'($urandom(seed));
        rst_n = 1'b0;
        adc_sample = '0;
        sample_strobe = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        apply_reset();
        check_passthrough_after_reset();
        sweep_select_codes();
        record_and_replay();
        mixed_record_replay();
        write_unused_addresses();
        reset_mid_run();
        idle(3);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
